// File: source/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // addi x0, x0, 0
    localparam word_t INSTR_NOP = 32'h0000_0013;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } if2id_s;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        reg_addr_t rd_addr;
        logic      rd_we;
        logic      load;
        logic      store;
        logic      branch;
        logic      bne;
        logic      jump;
    } id2exe_s;

    typedef struct packed {
        logic      we;
        reg_addr_t rd_addr;
        word_t     rd_data;
    } wrb_s;

endpackage

`default_nettype wire

// File: source/exe2mem_if.sv
`default_nettype none

// Registered execute result on its way to the memory stage
interface exe2mem_if
    import rv_core_pkg::*;
();

    logic      valid;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t rd_addr;
    logic      rd_we;
    logic      load;
    logic      store;

    modport exe (
        output valid, alu_result, store_data, rd_addr, rd_we, load, store
    );

    modport mem (
        input valid, alu_result, store_data, rd_addr, rd_we, load, store
    );

endinterface

`default_nettype wire

// File: source/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t RESET_VAL = '0
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     flush_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    // Flush takes priority over the incoming payload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_o <= RESET_VAL;
        end else if (flush_i) begin
            q_o <= RESET_VAL;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch.sv
`default_nettype none

module fetch
    import rv_core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  redirect_i,
    input  wire word_t redirect_pc_i,
    output logic       imem_req_o,
    output word_t      imem_addr_o,
    input  wire word_t imem_rdata_i,
    output if2id_s     if2id_o
);

    word_t pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    // No back-pressure, so the request is held every cycle
    assign imem_req_o  = 1'b1;
    assign imem_addr_o = pc;

    // Word on the bus is the wrong path while a redirect is pending
    assign if2id_o.instr = redirect_i ? INSTR_NOP : imem_rdata_i;
    assign if2id_o.pc    = pc;

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file
    import rv_core_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire reg_addr_t rs1_addr_i,
    input  wire reg_addr_t rs2_addr_i,
    output word_t          rs1_data_o,
    output word_t          rs2_data_o,
    input  wire wrb_s      wrb_i
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrb_i.we && (wrb_i.rd_addr != '0)) begin
            regs[wrb_i.rd_addr] <= wrb_i.rd_data;
        end
    end

    function automatic word_t read_port(reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wrb_i.we && (wrb_i.rd_addr == addr)) begin
            // Write in this cycle is visible right away
            data = wrb_i.rd_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

endmodule

`default_nettype wire

// File: source/decode.sv
`default_nettype none

module decode
    import rv_core_pkg::*;
(
    input  wire if2id_s if2id_i,
    output reg_addr_t   rs1_addr_o,
    output reg_addr_t   rs2_addr_o,
    input  wire word_t  rs1_data_i,
    input  wire word_t  rs2_data_i,
    output id2exe_s     id2exe_o
);

    word_t       instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_addr_t   rd_addr;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;

    assign instr   = if2id_i.instr;
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rd_addr = instr[11:7];

    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    // Sign-extended immediates of each format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        id2exe_o          = '0;
        id2exe_o.pc       = if2id_i.pc;
        id2exe_o.rs1_addr = rs1_addr_o;
        id2exe_o.rs2_addr = rs2_addr_o;
        id2exe_o.rs1_data = rs1_data_i;
        id2exe_o.rs2_data = rs2_data_i;
        id2exe_o.rd_addr  = rd_addr;
        id2exe_o.alu_op   = ALU_ADD;

        case (opcode)
            OPC_OP: begin
                id2exe_o.rd_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: id2exe_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: id2exe_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: id2exe_o.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: id2exe_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: id2exe_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: id2exe_o.alu_op = ALU_SLT;
                    default:              id2exe_o.rd_we  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                id2exe_o.rd_we   = (funct3 == 3'b000);
                id2exe_o.use_imm = 1'b1;
                id2exe_o.imm     = imm_i;
            end
            OPC_LUI: begin
                id2exe_o.rd_we   = 1'b1;
                id2exe_o.use_imm = 1'b1;
                id2exe_o.imm     = imm_u;
                id2exe_o.alu_op  = ALU_PASS_B;
            end
            OPC_LOAD: begin
                id2exe_o.load    = (funct3 == 3'b010);
                id2exe_o.rd_we   = (funct3 == 3'b010);
                id2exe_o.use_imm = 1'b1;
                id2exe_o.imm     = imm_i;
            end
            OPC_STORE: begin
                id2exe_o.store   = (funct3 == 3'b010);
                id2exe_o.use_imm = 1'b1;
                id2exe_o.imm     = imm_s;
            end
            OPC_BRANCH: begin
                id2exe_o.branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                id2exe_o.bne    = (funct3 == 3'b001);
                id2exe_o.imm    = imm_b;
            end
            OPC_JAL: begin
                id2exe_o.jump  = 1'b1;
                id2exe_o.rd_we = 1'b1;
                id2exe_o.imm   = imm_j;
            end
            default: begin
                // Anything else passes through as a bubble
            end
        endcase

        // Writes to x0 never leave decode
        if (rd_addr == '0) begin
            id2exe_o.rd_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/execute.sv
`default_nettype none

module execute
    import rv_core_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire id2exe_s id2exe_i,
    input  wire wrb_s    wrb_i,
    output logic         redirect_o,
    output word_t        redirect_pc_o,
    exe2mem_if.exe       exe2mem
);

    word_t rs1_fwd;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_out;
    word_t pc_plus4;
    word_t exe_result;
    logic  equal;
    logic  taken;

    // Operand bypass from the instruction now in memory/writeback
    function automatic word_t forward(reg_addr_t addr, word_t data);
        word_t value;
        value = data;
        if (wrb_i.we && (wrb_i.rd_addr != '0) && (wrb_i.rd_addr == addr)) begin
            value = wrb_i.rd_data;
        end
        return value;
    endfunction

    assign rs1_fwd = forward(id2exe_i.rs1_addr, id2exe_i.rs1_data);
    assign rs2_fwd = forward(id2exe_i.rs2_addr, id2exe_i.rs2_data);
    assign op_b    = id2exe_i.use_imm ? id2exe_i.imm : rs2_fwd;

    always_comb begin
        case (id2exe_i.alu_op)
            ALU_ADD:    alu_out = rs1_fwd + op_b;
            ALU_SUB:    alu_out = rs1_fwd - op_b;
            ALU_AND:    alu_out = rs1_fwd & op_b;
            ALU_OR:     alu_out = rs1_fwd | op_b;
            ALU_XOR:    alu_out = rs1_fwd ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // JAL links the return address
    assign pc_plus4   = id2exe_i.pc + word_t'(4);
    assign exe_result = id2exe_i.jump ? pc_plus4 : alu_out;

    // Branch resolution
    assign equal = (rs1_fwd == rs2_fwd);
    assign taken = id2exe_i.branch && (id2exe_i.bne ? !equal : equal);

    assign redirect_o    = taken || id2exe_i.jump;
    assign redirect_pc_o = id2exe_i.pc + id2exe_i.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe2mem.valid <= 1'b0;
            exe2mem.rd_we <= 1'b0;
            exe2mem.load  <= 1'b0;
            exe2mem.store <= 1'b0;
        end else begin
            exe2mem.valid <= id2exe_i.rd_we || id2exe_i.load || id2exe_i.store;
            exe2mem.rd_we <= id2exe_i.rd_we;
            exe2mem.load  <= id2exe_i.load;
            exe2mem.store <= id2exe_i.store;
        end
    end

    always_ff @(posedge clk) begin
        exe2mem.alu_result <= exe_result;
        exe2mem.store_data <= rs2_fwd;
        exe2mem.rd_addr    <= id2exe_i.rd_addr;
    end

endmodule

`default_nettype wire

// File: source/mem_writeback.sv
`default_nettype none

module mem_writeback
    import rv_core_pkg::*;
(
    exe2mem_if.mem     exe2mem,
    output logic       dbus_req_o,
    output logic       dbus_we_o,
    output word_t      dbus_addr_o,
    output word_t      dbus_wdata_o,
    input  wire word_t dbus_rdata_i,
    output wrb_s       wrb_o
);

    // Word accesses only, address straight from the ALU
    assign dbus_req_o   = exe2mem.valid && (exe2mem.load || exe2mem.store);
    assign dbus_we_o    = exe2mem.valid && exe2mem.store;
    assign dbus_addr_o  = exe2mem.alu_result;
    assign dbus_wdata_o = exe2mem.store_data;

    // Bus answers in the same cycle, so load data goes back directly
    assign wrb_o.we      = exe2mem.valid && exe2mem.rd_we;
    assign wrb_o.rd_addr = exe2mem.rd_addr;
    assign wrb_o.rd_data = exe2mem.load ? dbus_rdata_i : exe2mem.alu_result;

endmodule

`default_nettype wire

// File: source/core_top.sv
`default_nettype none

module core_top
    import rv_core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire logic  clk,
    input  wire logic  rst_n,

    // Instruction memory
    output logic       imem_req_o,
    output word_t      imem_addr_o,
    input  wire word_t imem_rdata_i,

    // Data bus
    output logic       dbus_req_o,
    output logic       dbus_we_o,
    output word_t      dbus_addr_o,
    output word_t      dbus_wdata_o,
    input  wire word_t dbus_rdata_i
);

    localparam if2id_s  IF2ID_RESET  = '{instr: INSTR_NOP, pc: RESET_PC};
    localparam id2exe_s ID2EXE_RESET = '0;

    if2id_s    if2id_d;
    if2id_s    if2id_q;
    id2exe_s   id2exe_d;
    id2exe_s   id2exe_q;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      redirect;
    word_t     redirect_pc;
    wrb_s      wrb;

    exe2mem_if exe2mem_bus ();

    fetch #(
        .RESET_PC (RESET_PC)
    ) fetch0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .if2id_o       (if2id_d)
    );

    // Fetch to decode boundary
    stage_reg #(
        .payload_t (if2id_s),
        .RESET_VAL (IF2ID_RESET)
    ) if2id_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (redirect),
        .d_i     (if2id_d),
        .q_o     (if2id_q)
    );

    decode decode0 (
        .if2id_i    (if2id_q),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id2exe_o   (id2exe_d)
    );

    reg_file reg_file0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wrb_i      (wrb)
    );

    // Decode to execute boundary
    stage_reg #(
        .payload_t (id2exe_s),
        .RESET_VAL (ID2EXE_RESET)
    ) id2exe_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (redirect),
        .d_i     (id2exe_d),
        .q_o     (id2exe_q)
    );

    execute execute0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .id2exe_i      (id2exe_q),
        .wrb_i         (wrb),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .exe2mem       (exe2mem_bus.exe)
    );

    mem_writeback mem_writeback0 (
        .exe2mem      (exe2mem_bus.mem),
        .dbus_req_o   (dbus_req_o),
        .dbus_we_o    (dbus_we_o),
        .dbus_addr_o  (dbus_addr_o),
        .dbus_wdata_o (dbus_wdata_o),
        .dbus_rdata_i (dbus_rdata_i),
        .wrb_o        (wrb)
    );

endmodule

`default_nettype wire

// File: bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 40;
localparam int HALT_IDX = PROG_LEN - 1;

// Instruction kinds known to the generator and the model
typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI,
    K_LUI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL
} kind_e;

logic [31:0] lfsr_state;
kind_e       kind_a [PROG_LEN];
logic [2:0]  rd_a   [PROG_LEN];
logic [2:0]  rs1_a  [PROG_LEN];
logic [2:0]  rs2_a  [PROG_LEN];
word_t       imm_a  [PROG_LEN];
word_t       prog   [PROG_LEN];
word_t       exp_addr [$];
word_t       exp_data [$];
word_t       halt_addr;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic word_t random_bits(int n);
    word_t bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_state = lfsr_next(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
endfunction

// Initial data memory contents, shared by the memory and the model
function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
endfunction

function automatic word_t encode(kind_e k, logic [2:0] rd, logic [2:0] rs1,
                                 logic [2:0] rs2, word_t imm);
    reg_addr_t d;
    reg_addr_t a;
    reg_addr_t b;
    word_t     w;
    d = {2'b00, rd};
    a = {2'b00, rs1};
    b = {2'b00, rs2};
    case (k)
        K_ADD:   w = {7'b0000000, b, a, 3'b000, d, OPC_OP};
        K_SUB:   w = {7'b0100000, b, a, 3'b000, d, OPC_OP};
        K_AND:   w = {7'b0000000, b, a, 3'b111, d, OPC_OP};
        K_OR:    w = {7'b0000000, b, a, 3'b110, d, OPC_OP};
        K_XOR:   w = {7'b0000000, b, a, 3'b100, d, OPC_OP};
        K_SLT:   w = {7'b0000000, b, a, 3'b010, d, OPC_OP};
        K_ADDI:  w = {imm[11:0], a, 3'b000, d, OPC_OP_IMM};
        K_LUI:   w = {imm[31:12], d, OPC_LUI};
        K_LW:    w = {imm[11:0], a, 3'b010, d, OPC_LOAD};
        K_SW:    w = {imm[11:5], b, a, 3'b010, imm[4:0], OPC_STORE};
        K_BEQ:   w = {imm[12], imm[10:5], b, a, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
        K_BNE:   w = {imm[12], imm[10:5], b, a, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
        default: w = {imm[20], imm[10:1], imm[11], imm[19:12], d, OPC_JAL};
    endcase
    return w;
endfunction

task automatic place(int i, kind_e k, logic [2:0] rd, logic [2:0] rs1,
                     logic [2:0] rs2, word_t imm);
    kind_a[i[5:0]] = k;
    rd_a[i[5:0]]   = rd;
    rs1_a[i[5:0]]  = rs1;
    rs2_a[i[5:0]]  = rs2;
    imm_a[i[5:0]]  = imm;
    prog[i[5:0]]   = encode(k, rd, rs1, rs2, imm);
endtask

task automatic gen_program();
    int         slot;
    int         span;
    word_t      r;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    lfsr_state = 32'h1ed25b86;
    // Directed start: load then use then store, and a dependent ADDI pair
    place(0, K_LW, 3'd1, 3'd0, 3'd0, 32'd8);
    place(1, K_ADD, 3'd2, 3'd1, 3'd1, '0);
    place(2, K_SW, 3'd0, 3'd0, 3'd2, 32'd12);
    place(3, K_ADDI, 3'd3, 3'd0, 3'd0, 32'd5);
    place(4, K_ADDI, 3'd3, 3'd3, 3'd0, 32'hffff_fff9);
    place(5, K_SW, 3'd0, 3'd0, 3'd3, 32'd16);
    for (int i = 6; i < HALT_IDX; i++) begin
        slot = int'(random_bits(4));
        span = int'(random_bits(2)) + 1;
        if (i + span > HALT_IDX) begin
            span = HALT_IDX - i;
        end
        r   = random_bits(20);
        rd  = 3'(random_bits(3));
        rs1 = 3'(random_bits(3));
        rs2 = 3'(random_bits(3));
        if (slot < 6) begin
            place(i, kind_e'(slot), rd, rs1, rs2, '0);
        end else if (slot < 8) begin
            place(i, K_ADDI, rd, rs1, rs2, {{20{r[11]}}, r[11:0]});
        end else if (slot == 8) begin
            place(i, K_LUI, rd, rs1, rs2, {r[19:0], 12'b0});
        end else if (slot < 11) begin
            place(i, K_LW, rd, 3'd0, rs2, {26'b0, r[3:0], 2'b00});
        end else if (slot < 14) begin
            place(i, K_SW, rd, 3'd0, rs2, {26'b0, r[3:0], 2'b00});
        end else if (slot == 14) begin
            place(i, r[4] ? K_BNE : K_BEQ, rd, rs1, rs2, word_t'(span * 4));
        end else begin
            place(i, K_JAL, rd, rs1, rs2, word_t'(span * 4));
        end
    end
    // JAL to itself is the halt
    place(HALT_IDX, K_JAL, 3'd0, 3'd0, 3'd0, '0);
endtask

// ISA-level execution of the program up to the halt
task automatic run_model();
    word_t regs [8];
    word_t mem  [16];
    word_t a;
    word_t b;
    word_t imm;
    word_t addr;
    word_t res;
    logic  wr;
    int    i;
    int    next;
    for (int k = 0; k < 8; k++) begin
        regs[k[2:0]] = '0;
    end
    for (int k = 0; k < 16; k++) begin
        mem[k[3:0]] = fill_word(word_t'(k * 4));
    end
    exp_addr.delete();
    exp_data.delete();
    i = 0;
    while (i != HALT_IDX) begin
        a    = regs[rs1_a[i[5:0]]];
        b    = regs[rs2_a[i[5:0]]];
        imm  = imm_a[i[5:0]];
        addr = a + imm;
        res  = '0;
        wr   = 1'b1;
        next = i + 1;
        case (kind_a[i[5:0]])
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDI: res = a + imm;
            K_LUI:  res = imm;
            K_LW:   res = mem[addr[5:2]];
            K_SW: begin
                wr = 1'b0;
                mem[addr[5:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            K_BEQ: begin
                wr = 1'b0;
                if (a == b) begin
                    next = i + int'(imm >> 2);
                end
            end
            K_BNE: begin
                wr = 1'b0;
                if (a != b) begin
                    next = i + int'(imm >> 2);
                end
            end
            default: begin
                res  = RESET_PC + word_t'((i + 1) * 4);
                next = i + int'(imm >> 2);
            end
        endcase
        if (wr && (rd_a[i[5:0]] != 3'd0)) begin
            regs[rd_a[i[5:0]]] = res;
        end
        i = next;
    end
    halt_addr = RESET_PC + word_t'(HALT_IDX * 4);
endtask

`endif

// File: bench/tb_core.sv
`default_nettype none

module tb_core
    import rv_core_pkg::*;
();

    localparam word_t RESET_PC = 32'h0000_0000;

    `include "tb_program.svh"

    // Longest path is every instruction paying the branch penalty
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 50;

    logic  clk;
    logic  rst_n;
    logic  imem_req;
    word_t imem_addr;
    word_t imem_rdata;
    logic  dbus_req;
    logic  dbus_we;
    word_t dbus_addr;
    word_t dbus_wdata;
    word_t dbus_rdata;

    word_t imem [64];
    word_t dmem [16];
    int    error_count;
    int    test_count;
    int    failed_tests;
    int    store_idx;
    int    halt_visits;
    int    cycle_count;

    core_top #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req_o   (imem_req),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dbus_req_o   (dbus_req),
        .dbus_we_o    (dbus_we),
        .dbus_addr_o  (dbus_addr),
        .dbus_wdata_o (dbus_wdata),
        .dbus_rdata_i (dbus_rdata)
    );

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[7:2]];
    assign dbus_rdata = dmem[dbus_addr[5:2]];

    always @(posedge clk) begin
        if (dbus_req && dbus_we) begin
            dmem[dbus_addr[5:2]] <= dbus_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_word(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED", name);
        end
    endtask

    // Store checker and halt detection
    always @(negedge clk) begin
        if (rst_n) begin
            if (dbus_req && dbus_we) begin
                if (store_idx < exp_addr.size()) begin
                    check_word($sformatf("store sequence: store %0d address", store_idx),
                               exp_addr[store_idx], dbus_addr);
                    check_word($sformatf("store sequence: store %0d data", store_idx),
                               exp_data[store_idx], dbus_wdata);
                end else begin
                    $display("Store %0d to address %h was not expected by the model",
                             store_idx, dbus_addr);
                    error_count++;
                end
                store_idx++;
            end
            if (imem_addr == halt_addr) begin
                halt_visits++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the core did not settle at the halt address within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int errors_before;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        store_idx    = 0;
        halt_visits  = 0;
        cycle_count  = 0;
        rst_n        = 1'b0;
        gen_program();
        run_model();
        for (int k = 0; k < 64; k++) begin
            if (k < PROG_LEN) begin
                imem[k[5:0]] = prog[k[5:0]];
            end else begin
                imem[k[5:0]] = INSTR_NOP;
            end
        end
        for (int k = 0; k < 16; k++) begin
            dmem[k[3:0]] <= fill_word(word_t'(k * 4));
        end

        errors_before = error_count;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_bit("reset: dbus_req_o", 1'b0, dbus_req);
            check_bit("reset: dbus_we_o", 1'b0, dbus_we);
        end
        check_bit("reset: imem_req_o", 1'b1, imem_req);
        check_word("reset: first fetch address", RESET_PC, imem_addr);
        rst_n = 1'b1;
        // First edge out of reset moves the PC on and drains only bubbles
        @(posedge clk);
        #1;
        check_bit("reset: dbus_req_o after release", 1'b0, dbus_req);
        check_bit("reset: dbus_we_o after release", 1'b0, dbus_we);
        check_word("reset: fetch address after release", RESET_PC + word_t'(4), imem_addr);
        finish_test("reset", errors_before);

        // By the third visit to the halt address every older store is done
        errors_before = error_count;
        wait (halt_visits >= 3);
        finish_test($sformatf("store sequence (%0d stores)", store_idx), errors_before);

        errors_before = error_count;
        // Halt loop is three cycles long
        repeat (3) @(negedge clk);
        check_word("completion: fetch address", halt_addr, imem_addr);
        check_count("completion: store count", exp_addr.size(), store_idx);
        finish_test("completion", errors_before);

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+bench
source/rv_core_pkg.sv
source/exe2mem_if.sv
source/stage_reg.sv
source/fetch.sv
source/reg_file.sv
source/decode.sv
source/execute.sv
source/mem_writeback.sv
source/core_top.sv
bench/tb_core.sv

// File: Makefile
TOP = tb_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --top-module $(TOP) -Mdir build -f filelist.f
	out=$$(./build/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf build
